/* project.f */
+incdir+logic
logic/pmem_pkg.sv
logic/pmem_mem_if.sv
logic/pmem_shared_buffer.sv
logic/pmem_ingress.sv
logic/pmem_tag_dispatch.sv
logic/pmem_transmit.sv
logic/pmem_group.sv
verification/pmem_group_tb.sv

/* Bender.yml */
package:
  name: pmem_group

sources:
  - include_dirs:
      - logic
    files:
      - logic/pmem_pkg.sv
      - logic/pmem_mem_if.sv
      - logic/pmem_shared_buffer.sv
      - logic/pmem_ingress.sv
      - logic/pmem_tag_dispatch.sv
      - logic/pmem_transmit.sv
      - logic/pmem_group.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/pmem_group_tb.sv

/* verification/pmem_group_tb.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_group_tb;

  localparam int N = `PMEM_NUM_PORTS;
  localparam int HANDLES = `PMEM_NUM_PORTS * `PMEM_SLOTS;
  localparam int NUM_PKTS = 24;
  localparam int STALL_LIMIT = 2000;
  localparam int RUN_LIMIT = 100000;

  logic clock;
  logic rst_n;
  logic [`PMEM_DATA_W-1:0] packetin_data [N];
  logic packetin_valid [N];
  logic packetin_sop [N];
  logic packetin_eop [N];
  logic [`PMEM_EMPTY_W-1:0] packetin_empty [N];
  logic packetin_ready [N];
  logic [`PMEM_DATA_W-1:0] packetout_data [N];
  logic packetout_valid [N];
  logic packetout_sop [N];
  logic packetout_eop [N];
  logic packetout_ready [N];
  pmem_pkg::pmem_handle_t packetout_channel [N];
  logic [`PMEM_DATA_W-1:0] transmitout_data [N];
  logic transmitout_valid [N];
  logic transmitout_sop [N];
  logic transmitout_eop [N];
  logic [`PMEM_EMPTY_W-1:0] transmitout_empty [N];
  logic transmitout_ready [N];
  logic [`PMEM_TAG_W-1:0] tagin_data;
  logic tagin_valid;
  logic tagin_ready;

  int seed;
  int cycle;
  int sent [N];
  int in_len [N];
  int in_idx [N];
  bit in_active [N];
  int in_stall [N];
  // {sop, eop, empty, data} per accepted packetin beat
  logic [68:0] pass_q [N][$];
  int po_idx [N];
  logic [5:0] po_chan [N];
  logic [`PMEM_SLOTS-1:0] held [N];
  logic [63:0] slot_data [HANDLES][`PMEM_SLOT_WORDS];
  int slot_len [HANDLES];
  logic [2:0] slot_empty [HANDLES];
  logic [5:0] tag_q [$];
  int tag_stall;
  logic [5:0] tx_q [N][$];
  int tx_idx [N];
  int tx_wait [N];
  int delivered;
  int dropped;

  pmem_group u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fffffff) % n;
  endfunction

  task automatic drive_ingress(input int p);
    bit last;
    if (packetin_valid[p] && packetin_ready[p]) begin
      pass_q[p].push_back({packetin_sop[p], packetin_eop[p], packetin_empty[p],
                           packetin_data[p]});
      in_stall[p] = 0;
      in_idx[p]++;
      if (packetin_eop[p]) begin
        in_active[p] = 1'b0;
        sent[p]++;
      end
    end else if (packetin_valid[p]) begin
      in_stall[p]++;
      if (in_stall[p] > STALL_LIMIT) begin
        fail_run($sformatf("Ingress port %0d stopped accepting beats", p));
      end
    end
    // A presented beat stays until it is taken
    if (!packetin_valid[p] || packetin_ready[p]) begin
      if (!in_active[p] && sent[p] < NUM_PKTS) begin
        in_active[p] = 1'b1;
        in_len[p] = 1 + rand_below(`PMEM_SLOT_WORDS);
        in_idx[p] = 0;
      end
      if (in_active[p] && rand_below(4) != 0) begin
        last = in_idx[p] == in_len[p] - 1;
        packetin_data[p] <= {$random(seed), $random(seed)};
        packetin_sop[p] <= in_idx[p] == 0;
        packetin_eop[p] <= last;
        packetin_empty[p] <= last ? 3'(rand_below(8)) : 3'd0;
        packetin_valid[p] <= 1'b1;
      end else begin
        packetin_valid[p] <= 1'b0;
      end
    end
  endtask

  task automatic match_passthrough(input int p);
    logic [68:0] beat;
    logic [5:0] ch;
    if (packetout_valid[p] && packetout_ready[p]) begin
      if (pass_q[p].size() == 0) begin
        fail_run($sformatf("Packetout port %0d sent a beat that never came in", p));
      end else begin
        beat = pass_q[p].pop_front();
        ch = packetout_channel[p];
        expect_equal($sformatf("packetout_data[%0d]", p), packetout_data[p], beat[63:0]);
        expect_equal($sformatf("packetout_sop[%0d]", p), packetout_sop[p], beat[68]);
        expect_equal($sformatf("packetout_eop[%0d]", p), packetout_eop[p], beat[67]);
        expect_equal($sformatf("packetout_channel[%0d] port", p), ch[5:4], p);
        if (beat[68]) begin
          expect_equal($sformatf("slot %0d busy on port %0d", ch[3:0], p),
                       held[p][ch[3:0]], 0);
          held[p][ch[3:0]] = 1'b1;
          po_chan[p] = ch;
          po_idx[p] = 0;
        end else begin
          expect_equal($sformatf("packetout_channel[%0d]", p), ch, po_chan[p]);
        end
        slot_data[ch][po_idx[p]] = beat[63:0];
        po_idx[p]++;
        // Whole packet seen, so the matcher may answer
        if (beat[67]) begin
          slot_len[ch] = po_idx[p];
          slot_empty[ch] = beat[66:64];
          tag_q.push_back(ch);
        end
      end
    end
  endtask

  task automatic score_transmit(input int d);
    logic [5:0] h;
    int idx;
    bit last;
    if (transmitout_valid[d] && transmitout_ready[d]) begin
      tx_wait[d] = 0;
      if (tx_q[d].size() == 0) begin
        fail_run($sformatf("Transmit port %0d sent a beat with no packet forwarded", d));
      end else begin
        h = tx_q[d][0];
        idx = tx_idx[d];
        last = idx == slot_len[h] - 1;
        expect_equal($sformatf("transmitout_data[%0d]", d), transmitout_data[d],
                     slot_data[h][idx]);
        expect_equal($sformatf("transmitout_sop[%0d]", d), transmitout_sop[d], idx == 0);
        expect_equal($sformatf("transmitout_eop[%0d]", d), transmitout_eop[d], last);
        expect_equal($sformatf("transmitout_empty[%0d]", d), transmitout_empty[d],
                     last ? slot_empty[h] : 3'd0);
        tx_idx[d]++;
        if (last) begin
          void'(tx_q[d].pop_front());
          tx_idx[d] = 0;
          held[h[5:4]][h[3:0]] = 1'b0;
          delivered++;
        end
      end
    end else if (tx_q[d].size() != 0) begin
      tx_wait[d]++;
      if (tx_wait[d] > STALL_LIMIT) begin
        fail_run($sformatf("Transmit port %0d never sent its forwarded packet", d));
      end
    end
  endtask

  task automatic settle_tag();
    logic [5:0] h;
    if (tagin_valid && tagin_ready) begin
      tag_stall = 0;
      h = tagin_data[5:0];
      if (tagin_data[9:8] == 2'd0) begin
        tx_q[tagin_data[7:6]].push_back(h);
      end else begin
        // Drop and both reserved actions free the slot
        held[h[5:4]][h[3:0]] = 1'b0;
        dropped++;
      end
    end else if (tagin_valid) begin
      tag_stall++;
      if (tag_stall > STALL_LIMIT) begin
        fail_run("The tag input stopped accepting tags");
      end
    end
  endtask

  task automatic offer_tag();
    int r;
    logic [1:0] act;
    logic [1:0] dst;
    logic [5:0] h;
    if (!tagin_valid || tagin_ready) begin
      if (tag_q.size() != 0 && rand_below(5) != 0) begin
        r = rand_below(10);
        act = r < 3 ? 2'd0 : (r < 8 ? 2'd1 : 2'(2 + rand_below(2)));
        dst = 2'(rand_below(N));
        h = tag_q.pop_front();
        tagin_data <= {act, dst, h};
        tagin_valid <= 1'b1;
      end else begin
        tagin_valid <= 1'b0;
      end
    end
  endtask

  function automatic bit all_done();
    bit done;
    done = tag_q.size() == 0 && !tagin_valid;
    for (int p = 0; p < N; p++) begin
      done &= sent[p] == NUM_PKTS && !packetin_valid[p];
      done &= pass_q[p].size() == 0 && tx_q[p].size() == 0;
    end
    return done;
  endfunction

  initial begin
    int drain;
    seed = 84340;
    cycle = 0;
    delivered = 0;
    dropped = 0;
    tag_stall = 0;
    rst_n = 1'b0;
    tagin_data = '0;
    tagin_valid = 1'b0;
    for (int p = 0; p < N; p++) begin
      packetin_data[p] = '0;
      packetin_valid[p] = 1'b0;
      packetin_sop[p] = 1'b0;
      packetin_eop[p] = 1'b0;
      packetin_empty[p] = '0;
      packetout_ready[p] = 1'b0;
      transmitout_ready[p] = 1'b0;
      sent[p] = 0;
      in_active[p] = 1'b0;
      in_stall[p] = 0;
      po_idx[p] = 0;
      held[p] = '0;
      tx_idx[p] = 0;
      tx_wait[p] = 0;
    end
    repeat (2) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);
    for (int p = 0; p < N; p++) begin
      expect_equal($sformatf("packetout_valid[%0d]", p), packetout_valid[p], 0);
      expect_equal($sformatf("transmitout_valid[%0d]", p), transmitout_valid[p], 0);
    end
    expect_equal("tagin_ready", tagin_ready, 0);

    drain = 0;
    while (drain < 32) begin
      for (int p = 0; p < N; p++) begin
        drive_ingress(p);
        match_passthrough(p);
        score_transmit(p);
      end
      settle_tag();
      offer_tag();
      for (int p = 0; p < N; p++) begin
        packetout_ready[p] <= rand_below(4) != 0;
        transmitout_ready[p] <= rand_below(4) != 0;
      end
      // Idle tail catches late or duplicated beats
      if (all_done()) begin
        drain++;
      end
      cycle++;
      if (cycle > RUN_LIMIT) begin
        fail_run("The run did not finish within the cycle limit");
      end
      @(posedge clock);
    end

    expect_equal("packets accounted", delivered + dropped, N * NUM_PKTS);
    for (int p = 0; p < N; p++) begin
      expect_equal($sformatf("busy slots on port %0d", p), held[p], 0);
    end
    $display("Delivered %0d packets, dropped %0d", delivered, dropped);
    $display("Verification passed");
    $finish;
  end

endmodule

/* logic/pmem_group.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_group (
  input logic clock,
  input logic rst_n,

  input logic [`PMEM_DATA_W-1:0] packetin_data [`PMEM_NUM_PORTS],
  input logic packetin_valid [`PMEM_NUM_PORTS],
  input logic packetin_sop [`PMEM_NUM_PORTS],
  input logic packetin_eop [`PMEM_NUM_PORTS],
  input logic [`PMEM_EMPTY_W-1:0] packetin_empty [`PMEM_NUM_PORTS],
  output logic packetin_ready [`PMEM_NUM_PORTS],

  // Passthrough towards the matcher
  output logic [`PMEM_DATA_W-1:0] packetout_data [`PMEM_NUM_PORTS],
  output logic packetout_valid [`PMEM_NUM_PORTS],
  output logic packetout_sop [`PMEM_NUM_PORTS],
  output logic packetout_eop [`PMEM_NUM_PORTS],
  input logic packetout_ready [`PMEM_NUM_PORTS],
  output pmem_pkg::pmem_handle_t packetout_channel [`PMEM_NUM_PORTS],

  output logic [`PMEM_DATA_W-1:0] transmitout_data [`PMEM_NUM_PORTS],
  output logic transmitout_valid [`PMEM_NUM_PORTS],
  output logic transmitout_sop [`PMEM_NUM_PORTS],
  output logic transmitout_eop [`PMEM_NUM_PORTS],
  output logic [`PMEM_EMPTY_W-1:0] transmitout_empty [`PMEM_NUM_PORTS],
  input logic transmitout_ready [`PMEM_NUM_PORTS],

  // Match results
  input logic [`PMEM_TAG_W-1:0] tagin_data,
  input logic tagin_valid,
  output logic tagin_ready
);

  localparam int N = `PMEM_NUM_PORTS;

  pmem_mem_if mem_if [`PMEM_NUM_AGENTS] ();

  logic [N-1:0] q_valid;
  logic [N-1:0] q_ready;
  pmem_pkg::pmem_handle_t q_handle [N];
  logic [N-1:0] done_valid;
  pmem_pkg::pmem_handle_t done_handle [N];
  logic drop_valid;
  pmem_pkg::pmem_handle_t drop_handle;
  logic [`PMEM_NUM_RELEASE-1:0] release_valid;
  pmem_pkg::pmem_handle_t release_handle [`PMEM_NUM_RELEASE];

  // Drop path rides on the last release lane
  assign release_valid = {drop_valid, done_valid};
  assign release_handle[N] = drop_handle;

  for (genvar i = 0; i < N; i++) begin : g_port
    assign release_handle[i] = done_handle[i];

    pmem_ingress #(
      .PORT_ID(i)
    ) u_ingress (
      .clock(clock),
      .rst_n(rst_n),
      .packetin_data(packetin_data[i]),
      .packetin_valid(packetin_valid[i]),
      .packetin_sop(packetin_sop[i]),
      .packetin_eop(packetin_eop[i]),
      .packetin_empty(packetin_empty[i]),
      .packetin_ready(packetin_ready[i]),
      .packetout_data(packetout_data[i]),
      .packetout_valid(packetout_valid[i]),
      .packetout_sop(packetout_sop[i]),
      .packetout_eop(packetout_eop[i]),
      .packetout_channel(packetout_channel[i]),
      .packetout_ready(packetout_ready[i]),
      .release_valid(release_valid),
      .release_handle(release_handle),
      .mem(mem_if[i])
    );

    pmem_transmit u_transmit (
      .clock(clock),
      .rst_n(rst_n),
      .q_valid(q_valid[i]),
      .q_handle(q_handle[i]),
      .q_ready(q_ready[i]),
      .transmitout_data(transmitout_data[i]),
      .transmitout_valid(transmitout_valid[i]),
      .transmitout_sop(transmitout_sop[i]),
      .transmitout_eop(transmitout_eop[i]),
      .transmitout_empty(transmitout_empty[i]),
      .transmitout_ready(transmitout_ready[i]),
      .done_valid(done_valid[i]),
      .done_handle(done_handle[i]),
      .mem(mem_if[i + N])
    );
  end

  pmem_tag_dispatch u_dispatch (
    .clock(clock),
    .rst_n(rst_n),
    .tagin_data(pmem_pkg::pmem_tag_t'(tagin_data)),
    .tagin_valid(tagin_valid),
    .tagin_ready(tagin_ready),
    .q_valid(q_valid),
    .q_handle(q_handle),
    .q_ready(q_ready),
    .drop_valid(drop_valid),
    .drop_handle(drop_handle)
  );

  pmem_shared_buffer u_buffer (
    .clock(clock),
    .rst_n(rst_n),
    .agents(mem_if)
  );

endmodule

/* logic/pmem_transmit.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_transmit (
  input logic clock,
  input logic rst_n,
  input logic q_valid,
  input pmem_pkg::pmem_handle_t q_handle,
  output logic q_ready,
  output logic [`PMEM_DATA_W-1:0] transmitout_data,
  output logic transmitout_valid,
  output logic transmitout_sop,
  output logic transmitout_eop,
  output logic [`PMEM_EMPTY_W-1:0] transmitout_empty,
  input logic transmitout_ready,
  output logic done_valid,
  output pmem_pkg::pmem_handle_t done_handle,
  pmem_mem_if.agent mem
);

  localparam int IDX_W = $clog2(`PMEM_SLOT_WORDS);

  pmem_pkg::tx_state_e state;
  pmem_pkg::pmem_handle_t handle;
  logic [IDX_W-1:0] widx;
  logic inflight;
  logic first;
  logic beat_done;

  assign q_ready = state == pmem_pkg::tx_idle;

  // One read at a time, only into an empty output register
  assign mem.req = state == pmem_pkg::tx_read && !transmitout_valid && !inflight;
  assign mem.we = 1'b0;
  assign mem.addr = {handle, widx};
  assign mem.wdata = '0;

  assign beat_done = transmitout_valid && transmitout_ready;
  assign done_handle = handle;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= pmem_pkg::tx_idle;
      inflight <= 1'b0;
      transmitout_valid <= 1'b0;
      done_valid <= 1'b0;
      widx <= '0;
      first <= 1'b0;
    end else begin
      done_valid <= 1'b0;
      if (mem.req && mem.gnt) begin
        inflight <= 1'b1;
        widx <= widx + 1'b1;
      end
      if (mem.rvalid) begin
        inflight <= 1'b0;
        transmitout_valid <= 1'b1;
        first <= 1'b0;
      end else if (beat_done) begin
        transmitout_valid <= 1'b0;
      end
      case (state)
        pmem_pkg::tx_idle: begin
          if (q_valid) begin
            widx <= '0;
            first <= 1'b1;
            state <= pmem_pkg::tx_read;
          end
        end
        pmem_pkg::tx_read: begin
          if (mem.rvalid && mem.rdata.eop) begin
            state <= pmem_pkg::tx_send;
          end
        end
        pmem_pkg::tx_send: begin
          // Slot goes back once the eop beat has left
          if (beat_done && transmitout_eop) begin
            done_valid <= 1'b1;
            state <= pmem_pkg::tx_idle;
          end
        end
        default: state <= pmem_pkg::tx_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (q_valid && q_ready) begin
      handle <= q_handle;
    end
    if (mem.rvalid) begin
      transmitout_data <= mem.rdata.data;
      transmitout_eop <= mem.rdata.eop;
      transmitout_empty <= mem.rdata.empty;
      transmitout_sop <= first;
    end
  end

  // Buffer returns data only for reads this engine issued
  assert property (@(posedge clock) disable iff (!rst_n) mem.rvalid |-> inflight);

endmodule

/* logic/pmem_tag_dispatch.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_tag_dispatch (
  input logic clock,
  input logic rst_n,
  input pmem_pkg::pmem_tag_t tagin_data,
  input logic tagin_valid,
  output logic tagin_ready,
  output logic [`PMEM_NUM_PORTS-1:0] q_valid,
  output pmem_pkg::pmem_handle_t q_handle [`PMEM_NUM_PORTS],
  input logic [`PMEM_NUM_PORTS-1:0] q_ready,
  output logic drop_valid,
  output pmem_pkg::pmem_handle_t drop_handle
);

  localparam int N = `PMEM_NUM_PORTS;
  localparam int DEPTH = `PMEM_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int PORT_W = $clog2(N);

  logic is_fwd;
  logic fire;
  logic [N-1:0] full;
  logic [N-1:0] push;
  logic [N-1:0] pop;
  logic [PTR_W-1:0] wr_ptr [N];
  logic [PTR_W-1:0] rd_ptr [N];
  logic [CNT_W-1:0] count [N];
  pmem_pkg::pmem_handle_t fifo [N][DEPTH];

  always_comb begin
    case (tagin_data.action)
      pmem_pkg::act_forward: is_fwd = 1'b1;
      pmem_pkg::act_drop: is_fwd = 1'b0;
      // reserved codes act as drop
      default: is_fwd = 1'b0;
    endcase
  end

  // Forward stalls on a full destination queue, drop never does
  assign tagin_ready = tagin_valid && !(is_fwd && full[tagin_data.dest]);
  assign fire = tagin_valid && tagin_ready;

  assign drop_valid = fire && !is_fwd;
  assign drop_handle = tagin_data.handle;

  for (genvar p = 0; p < N; p++) begin : g_queue
    assign full[p] = count[p] == CNT_W'(DEPTH);
    assign push[p] = fire && is_fwd && tagin_data.dest == PORT_W'(p);
    assign pop[p] = q_valid[p] && q_ready[p];
    assign q_valid[p] = count[p] != '0;
    assign q_handle[p] = fifo[p][rd_ptr[p]];

    always_ff @(posedge clock) begin
      if (!rst_n) begin
        wr_ptr[p] <= '0;
        rd_ptr[p] <= '0;
        count[p] <= '0;
      end else begin
        if (push[p]) begin
          wr_ptr[p] <= wr_ptr[p] + 1'b1;
        end
        if (pop[p]) begin
          rd_ptr[p] <= rd_ptr[p] + 1'b1;
        end
        count[p] <= count[p] + CNT_W'(push[p]) - CNT_W'(pop[p]);
      end
    end

    always_ff @(posedge clock) begin
      if (push[p]) begin
        fifo[p][wr_ptr[p]] <= tagin_data.handle;
      end
    end

    // Occupancy stays in range and agrees with the pointers
    assert property (@(posedge clock) disable iff (!rst_n)
      count[p] <= CNT_W'(DEPTH) &&
      PTR_W'(wr_ptr[p] - rd_ptr[p]) == count[p][PTR_W-1:0]);
  end

endmodule

/* logic/pmem_ingress.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_ingress #(
  parameter int PORT_ID = 0
) (
  input logic clock,
  input logic rst_n,
  input logic [`PMEM_DATA_W-1:0] packetin_data,
  input logic packetin_valid,
  input logic packetin_sop,
  input logic packetin_eop,
  input logic [`PMEM_EMPTY_W-1:0] packetin_empty,
  output logic packetin_ready,
  output logic [`PMEM_DATA_W-1:0] packetout_data,
  output logic packetout_valid,
  output logic packetout_sop,
  output logic packetout_eop,
  output pmem_pkg::pmem_handle_t packetout_channel,
  input logic packetout_ready,
  input logic [`PMEM_NUM_RELEASE-1:0] release_valid,
  input pmem_pkg::pmem_handle_t release_handle [`PMEM_NUM_RELEASE],
  pmem_mem_if.agent mem
);

  localparam int SLOT_W = $clog2(`PMEM_SLOTS);
  localparam int IDX_W = $clog2(`PMEM_SLOT_WORDS);
  localparam int PORT_W = $clog2(`PMEM_NUM_PORTS);

  logic [`PMEM_SLOTS-1:0] free;
  logic in_pkt;
  logic have_slot;
  logic [SLOT_W-1:0] cur_slot;
  logic [SLOT_W-1:0] alloc_slot;
  logic [IDX_W-1:0] wcnt;
  logic [IDX_W-1:0] beat_idx;
  pmem_pkg::pmem_handle_t beat_handle;
  logic out_free;
  logic fire;

  // Lowest free slot
  always_comb begin
    alloc_slot = '0;
    for (int i = `PMEM_SLOTS - 1; i >= 0; i--) begin
      if (free[i]) begin
        alloc_slot = SLOT_W'(i);
      end
    end
  end

  assign have_slot = in_pkt || (|free);
  assign out_free = !packetout_valid || packetout_ready;
  assign beat_idx = in_pkt ? wcnt : '0;
  assign beat_handle.port = PORT_W'(PORT_ID);
  assign beat_handle.slot = in_pkt ? cur_slot : alloc_slot;

  assign mem.req = packetin_valid && have_slot && out_free;
  assign mem.we = 1'b1;
  // handle * SLOT_WORDS + word index
  assign mem.addr = {beat_handle, beat_idx};
  assign mem.wdata = '{data: packetin_data, eop: packetin_eop, empty: packetin_empty};

  assign packetin_ready = have_slot && mem.gnt && out_free;
  assign fire = packetin_valid && packetin_ready;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      free <= '1;
      in_pkt <= 1'b0;
      wcnt <= '0;
    end else begin
      if (fire) begin
        in_pkt <= !packetin_eop;
        wcnt <= beat_idx + 1'b1;
        if (!in_pkt) begin
          free[alloc_slot] <= 1'b0;
        end
      end
      // Only handles owned by this port
      for (int r = 0; r < `PMEM_NUM_RELEASE; r++) begin
        if (release_valid[r] && release_handle[r].port == PORT_W'(PORT_ID)) begin
          free[release_handle[r].slot] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      packetout_valid <= 1'b0;
    end else if (out_free) begin
      packetout_valid <= fire;
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      packetout_data <= packetin_data;
      packetout_sop <= packetin_sop;
      packetout_eop <= packetin_eop;
      packetout_channel <= beat_handle;
    end
    if (fire && !in_pkt) begin
      cur_slot <= alloc_slot;
    end
  end

  // Packet must end within its slot
  assert property (@(posedge clock) disable iff (!rst_n)
    fire && in_pkt && wcnt == IDX_W'(`PMEM_SLOT_WORDS - 1) |-> packetin_eop);

  assert property (@(posedge clock) disable iff (!rst_n)
    fire && in_pkt |-> !packetin_sop);

endmodule

/* logic/pmem_shared_buffer.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

module pmem_shared_buffer (
  input logic clock,
  input logic rst_n,
  pmem_mem_if.buffer agents [`PMEM_NUM_AGENTS]
);

  localparam int N = `PMEM_NUM_AGENTS;
  localparam int SEL_W = $clog2(N);

  logic [N-1:0] req;
  logic [N-1:0] we;
  logic [N-1:0] gnt;
  logic [`PMEM_ADDR_W-1:0] addr [N];
  pmem_pkg::pmem_word_t wdata [N];
  logic [SEL_W-1:0] ptr;
  logic [SEL_W-1:0] sel;
  logic any_gnt;
  logic [N-1:0] rvalid_q;
  pmem_pkg::pmem_word_t rdata_q;
  pmem_pkg::pmem_word_t ram [2**`PMEM_ADDR_W];

  for (genvar i = 0; i < N; i++) begin : g_agent
    assign req[i] = agents[i].req;
    assign we[i] = agents[i].we;
    assign addr[i] = agents[i].addr;
    assign wdata[i] = agents[i].wdata;
    assign agents[i].gnt = gnt[i];
    assign agents[i].rdata = rdata_q;
    assign agents[i].rvalid = rvalid_q[i];
  end

  // First requester at or after the pointer wins
  always_comb begin
    logic [SEL_W-1:0] idx;
    any_gnt = 1'b0;
    sel = ptr;
    for (int k = 0; k < N; k++) begin
      idx = ptr + SEL_W'(k);
      if (!any_gnt && req[idx]) begin
        any_gnt = 1'b1;
        sel = idx;
      end
    end
  end

  assign gnt = any_gnt ? (N'(1) << sel) : '0;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ptr <= '0;
      rvalid_q <= '0;
    end else begin
      if (any_gnt) begin
        ptr <= sel + 1'b1;
      end
      rvalid_q <= (any_gnt && !we[sel]) ? gnt : '0;
    end
  end

  // Single port, so a granted access is either a write or a read
  always_ff @(posedge clock) begin
    if (any_gnt) begin
      if (we[sel]) begin
        ram[addr[sel]] <= wdata[sel];
      end else begin
        rdata_q <= ram[addr[sel]];
      end
    end
  end

  assert property (@(posedge clock) disable iff (!rst_n) $onehot0(gnt));

endmodule

/* logic/pmem_mem_if.sv */
`timescale 1ns/1ps
`include "pmem_params.svh"

interface pmem_mem_if;

  logic req;
  logic we;
  logic [`PMEM_ADDR_W-1:0] addr;
  pmem_pkg::pmem_word_t wdata;

  // gnt is combinational from req, rdata lands one cycle after a read grant
  logic gnt;
  pmem_pkg::pmem_word_t rdata;
  logic rvalid;

  modport agent (
    output req,
    output we,
    output addr,
    output wdata,
    input gnt,
    input rdata,
    input rvalid
  );

  modport buffer (
    input req,
    input we,
    input addr,
    input wdata,
    output gnt,
    output rdata,
    output rvalid
  );

endinterface

/* logic/pmem_pkg.sv */
`include "pmem_params.svh"

package pmem_pkg;

  // One buffer entry
  typedef struct packed {
    logic [`PMEM_DATA_W-1:0] data;
    logic eop;
    logic [`PMEM_EMPTY_W-1:0] empty;
  } pmem_word_t;

  // Owning ingress port and slot index, also the packetout channel
  typedef struct packed {
    logic [$clog2(`PMEM_NUM_PORTS)-1:0] port;
    logic [$clog2(`PMEM_SLOTS)-1:0] slot;
  } pmem_handle_t;

  typedef enum logic [1:0] {
    act_forward = 2'd0,
    act_drop = 2'd1,
    act_rsvd2 = 2'd2,
    act_rsvd3 = 2'd3
  } pmem_action_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_read,
    tx_send
  } tx_state_e;

  // Matcher result as seen on tagin_data
  typedef struct packed {
    pmem_action_e action;
    logic [$clog2(`PMEM_NUM_PORTS)-1:0] dest;
    pmem_handle_t handle;
  } pmem_tag_t;

endpackage

/* logic/pmem_params.svh */
`ifndef PMEM_PARAMS_SVH
`define PMEM_PARAMS_SVH

// Switch geometry
`define PMEM_NUM_PORTS 4
`define PMEM_SLOTS 16
`define PMEM_SLOT_WORDS 8

// Four writers and four readers on the buffer
`define PMEM_NUM_AGENTS 8

// Transmit engines plus the drop path
`define PMEM_NUM_RELEASE 5

// 64 slots of 8 words
`define PMEM_ADDR_W 9
`define PMEM_QUEUE_DEPTH 4

`define PMEM_DATA_W 64
`define PMEM_EMPTY_W 3
`define PMEM_TAG_W 10

`endif
